//--- src/cshPkg.sv
// Shared requester indices and diagnostic word layout imported by the cache control modules
`default_nettype none

package cshPkg;

  // Requester slots in the request and cycle-type vectors
  localparam int reqMb = 3;
  localparam int reqChan = 2;
  localparam int reqEbox = 1;
  localparam int reqCca = 0;

  // Priority order is mb, chan, ebox, cca
  localparam int numReq = 4;

  localparam int diagWidth = 8;

  // Status bits from most significant down
  typedef struct packed {
    logic eboxCyc;
    logic mbCyc;
    logic chanCyc;
    logic ccaCyc;
    logic cacheIdle;
    logic coreRdReq;
    logic eboxBusy;
    logic portBusy;
  } diagFields_s;

  // Filled by field and read back by select code
  typedef union packed {
    diagFields_s fields;
    logic [diagWidth-1:0] raw;
  } diagWord_u;

endpackage

`default_nettype wire

//--- src/cycleControl.sv
// Request arbitration, cycle type hold, cache idle tracking and diagnostic readback
`timescale 1ns/100ps
`default_nettype none

module cycleControl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      mbValid,
  input  logic                      chanValid,
  input  logic                      eboxValid,
  input  logic                      ccaValid,
  input  logic                      eboxDone,
  input  logic                      portDone,
  input  logic                      coreRdReq,
  input  logic [2:0]                diagSel,
  output logic                      mbReady,
  output logic                      chanReady,
  output logic                      eboxReady,
  output logic                      ccaReady,
  output logic                      eboxStart,
  output logic                      portStart,
  output logic [cshPkg::numReq-1:0] cycType,
  output logic                      cacheIdle,
  output logic                      diagBit
);

  import cshPkg::*;

  logic [numReq-1:0] grant;
  logic              anyGrant;
  logic              eboxBusyQ;
  logic              portBusyQ;
  logic              eboxBusy;
  logic              portBusy;
  diagWord_u         diagWord;

  // Fixed priority, only while idle
  assign mbReady = cacheIdle & mbValid;
  assign chanReady = cacheIdle & chanValid & ~mbValid;
  assign eboxReady = cacheIdle & eboxValid & ~mbValid & ~chanValid;
  assign ccaReady = cacheIdle & ccaValid & ~mbValid & ~chanValid & ~eboxValid;

  always_comb begin
    grant = '0;
    grant[reqMb] = mbReady;
    grant[reqChan] = chanReady;
    grant[reqEbox] = eboxReady;
    grant[reqCca] = ccaReady;
  end

  assign anyGrant = |grant;

  always_ff @(posedge clk) begin
    if (rst) begin
      cycType <= '0;
      eboxStart <= 1'b0;
      portStart <= 1'b0;
      cacheIdle <= 1'b1;
    end else begin
      eboxStart <= eboxReady;
      // Everything but EBOX runs on the port chain
      portStart <= anyGrant & ~eboxReady;
      if (anyGrant) begin
        cycType <= grant;
        cacheIdle <= 1'b0;
      end else if (eboxDone | portDone) begin
        cycType <= '0;
        cacheIdle <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      eboxBusyQ <= 1'b0;
      portBusyQ <= 1'b0;
    end else begin
      if (eboxStart) begin
        eboxBusyQ <= 1'b1;
      end else if (eboxDone) begin
        eboxBusyQ <= 1'b0;
      end
      if (portStart) begin
        portBusyQ <= 1'b1;
      end else if (portDone) begin
        portBusyQ <= 1'b0;
      end
    end
  end

  // Covers T0 through the done cycle
  assign eboxBusy = eboxStart | eboxBusyQ;
  assign portBusy = portStart | portBusyQ;

  always_comb begin
    diagWord.fields.eboxCyc = cycType[reqEbox];
    diagWord.fields.mbCyc = cycType[reqMb];
    diagWord.fields.chanCyc = cycType[reqChan];
    diagWord.fields.ccaCyc = cycType[reqCca];
    diagWord.fields.cacheIdle = cacheIdle;
    diagWord.fields.coreRdReq = coreRdReq;
    diagWord.fields.eboxBusy = eboxBusy;
    diagWord.fields.portBusy = portBusy;
  end

  assign diagBit = diagWord.raw[diagSel];

endmodule

`default_nettype wire

//--- src/eboxSequencer.sv
// EBOX cycle timing, T0 to T3 with tag check at T2 and the core read wait on a miss
`timescale 1ns/100ps
`default_nettype none

module eboxSequencer #(
  parameter int numWays = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               eboxStart,
  input  logic               eboxRead,
  input  logic [numWays-1:0] validMatch,
  input  logic [numWays-1:0] wdVal,
  input  logic               coreDataValid,
  output logic               eboxResp,
  output logic               eboxDone,
  output logic               cacheWrEn,
  output logic               coreWrReq,
  output logic               coreRdReq
);

  logic t0;
  logic t1;
  logic t2;
  logic t3;
  logic rdWaitQ;
  logic respQ;
  logic busy;
  logic readQ;
  logic anyMatchQ;
  logic rdFoundQ;
  logic rdHitT3;
  logic rdMissT3;

  assign t0 = eboxStart;

  always_ff @(posedge clk) begin
    if (rst) begin
      t1 <= 1'b0;
      t2 <= 1'b0;
      t3 <= 1'b0;
    end else begin
      t1 <= t0;
      t2 <= t1;
      t3 <= t2;
    end
  end

  assign busy = t0 | t1 | t2 | t3 | rdWaitQ | respQ;

  // Tracks eboxRead while idle, so the value at acceptance is what gets held
  always_ff @(posedge clk) begin
    if (!busy) begin
      readQ <= eboxRead;
    end
  end

  // Tag results taken at T2
  always_ff @(posedge clk) begin
    if (t2) begin
      anyMatchQ <= |validMatch;
      rdFoundQ <= |(validMatch & wdVal);
    end
  end

  assign rdHitT3 = t3 & readQ & anyMatchQ & rdFoundQ;
  assign rdMissT3 = t3 & readQ & ~(anyMatchQ & rdFoundQ);

  assign cacheWrEn = t3 & ~readQ & anyMatchQ;
  assign coreWrReq = t3 & ~readQ & ~anyMatchQ;

  // Held through the cycle that returns the data
  assign coreRdReq = rdMissT3 | rdWaitQ;

  always_ff @(posedge clk) begin
    if (rst) begin
      rdWaitQ <= 1'b0;
      respQ <= 1'b0;
    end else begin
      rdWaitQ <= coreRdReq & ~coreDataValid;
      respQ <= coreRdReq & coreDataValid;
    end
  end

  assign eboxResp = rdHitT3 | respQ;
  assign eboxDone = (t3 & ~rdMissT3) | respQ;

endmodule

`default_nettype wire

//--- src/portSequencer.sv
// Non-EBOX cycle timing for memory-buffer fill, channel access and sweep invalidate
`timescale 1ns/100ps
`default_nettype none

module portSequencer #(
  parameter int numWays = 4
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      portStart,
  input  logic [cshPkg::numReq-1:0] cycType,
  input  logic                      chanToMem,
  input  logic                      ccaInvalEn,
  input  logic [numWays-1:0]        validMatch,
  output logic                      fillWrEn,
  output logic                      chanWrCache,
  output logic                      chanRdCache,
  output logic                      ccaInval,
  output logic                      portDone
);

  import cshPkg::*;

  logic t0;
  logic t1;
  logic t2;
  logic t3;
  logic busy;
  logic chanToMemQ;
  logic invalEnQ;
  logic anyMatchQ;
  logic chanHitT3;

  assign t0 = portStart;

  always_ff @(posedge clk) begin
    if (rst) begin
      t1 <= 1'b0;
      t2 <= 1'b0;
      t3 <= 1'b0;
    end else begin
      t1 <= t0;
      t2 <= t1;
      t3 <= t2;
    end
  end

  assign busy = t0 | t1 | t2 | t3;

  // Attributes follow the requester until the chain starts
  always_ff @(posedge clk) begin
    if (!busy) begin
      chanToMemQ <= chanToMem;
      invalEnQ <= ccaInvalEn;
    end
  end

  always_ff @(posedge clk) begin
    if (t2) begin
      anyMatchQ <= |validMatch;
    end
  end

  // Fill word goes in whether or not the line hits
  assign fillWrEn = t3 & cycType[reqMb];

  assign chanHitT3 = t3 & cycType[reqChan] & anyMatchQ;
  assign chanWrCache = chanHitT3 & chanToMemQ;
  assign chanRdCache = chanHitT3 & ~chanToMemQ;

  assign ccaInval = t3 & cycType[reqCca] & invalEnQ & anyMatchQ;

  assign portDone = t3;

endmodule

`default_nettype wire

//--- src/cacheControl.sv
// Cache control top level, ties arbitration to the EBOX and port sequencers
`timescale 1ns/100ps
`default_nettype none

module cacheControl #(
  parameter int numWays = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               mbValid,
  output logic               mbReady,
  input  logic               chanValid,
  output logic               chanReady,
  input  logic               chanToMem,
  input  logic               eboxValid,
  output logic               eboxReady,
  input  logic               eboxRead,
  input  logic               ccaValid,
  output logic               ccaReady,
  input  logic               ccaInvalEn,
  input  logic [numWays-1:0] validMatch,
  input  logic [numWays-1:0] wdVal,
  input  logic               coreDataValid,
  input  logic [2:0]         diagSel,
  output logic               diagBit,
  output logic               cacheIdle,
  output logic               eboxResp,
  output logic               cacheWrEn,
  output logic               coreWrReq,
  output logic               coreRdReq,
  output logic               fillWrEn,
  output logic               chanWrCache,
  output logic               chanRdCache,
  output logic               ccaInval
);

  import cshPkg::*;

  logic              eboxStart;
  logic              portStart;
  logic              eboxDone;
  logic              portDone;
  logic [numReq-1:0] cycType;

  cycleControl i_cycleControl (
    .clk       (clk),
    .rst       (rst),
    .mbValid   (mbValid),
    .chanValid (chanValid),
    .eboxValid (eboxValid),
    .ccaValid  (ccaValid),
    .eboxDone  (eboxDone),
    .portDone  (portDone),
    .coreRdReq (coreRdReq),
    .diagSel   (diagSel),
    .mbReady   (mbReady),
    .chanReady (chanReady),
    .eboxReady (eboxReady),
    .ccaReady  (ccaReady),
    .eboxStart (eboxStart),
    .portStart (portStart),
    .cycType   (cycType),
    .cacheIdle (cacheIdle),
    .diagBit   (diagBit)
  );

  eboxSequencer #(.numWays(numWays)) i_eboxSequencer (
    .clk           (clk),
    .rst           (rst),
    .eboxStart     (eboxStart),
    .eboxRead      (eboxRead),
    .validMatch    (validMatch),
    .wdVal         (wdVal),
    .coreDataValid (coreDataValid),
    .eboxResp      (eboxResp),
    .eboxDone      (eboxDone),
    .cacheWrEn     (cacheWrEn),
    .coreWrReq     (coreWrReq),
    .coreRdReq     (coreRdReq)
  );

  portSequencer #(.numWays(numWays)) i_portSequencer (
    .clk         (clk),
    .rst         (rst),
    .portStart   (portStart),
    .cycType     (cycType),
    .chanToMem   (chanToMem),
    .ccaInvalEn  (ccaInvalEn),
    .validMatch  (validMatch),
    .fillWrEn    (fillWrEn),
    .chanWrCache (chanWrCache),
    .chanRdCache (chanRdCache),
    .ccaInval    (ccaInval),
    .portDone    (portDone)
  );

endmodule

`default_nettype wire

//--- verif/cacheControl_props.sv
// Handshake and cycle sequencing assertions, bound into every cycleControl instance
`timescale 1ns/100ps
`default_nettype none

module cycleControlProps (
  input logic clk,
  input logic rst,
  input logic mbValid,
  input logic chanValid,
  input logic eboxValid,
  input logic ccaValid,
  input logic mbReady,
  input logic chanReady,
  input logic eboxReady,
  input logic ccaReady,
  input logic cacheIdle,
  input logic eboxStart,
  input logic portStart,
  input logic eboxDone,
  input logic portDone
);

  logic inCycle;

  // Set by a start, cleared by the matching done
  always_ff @(posedge clk) begin
    if (rst) begin
      inCycle <= 1'b0;
    end else if (eboxStart | portStart) begin
      inCycle <= 1'b1;
    end else if (eboxDone | portDone) begin
      inCycle <= 1'b0;
    end
  end

  assert property (@(posedge clk) disable iff (rst)
    $onehot0({mbReady, chanReady, eboxReady, ccaReady}))
    else $error("more than one ready high");

  assert property (@(posedge clk) disable iff (rst) mbReady |-> mbValid && cacheIdle)
    else $error("mbReady without mbValid or idle");
  assert property (@(posedge clk) disable iff (rst) chanReady |-> chanValid && cacheIdle)
    else $error("chanReady without chanValid or idle");
  assert property (@(posedge clk) disable iff (rst) eboxReady |-> eboxValid && cacheIdle)
    else $error("eboxReady without eboxValid or idle");
  assert property (@(posedge clk) disable iff (rst) ccaReady |-> ccaValid && cacheIdle)
    else $error("ccaReady without ccaValid or idle");

  assert property (@(posedge clk) disable iff (rst) (eboxStart || portStart) |-> !inCycle)
    else $error("start issued before the previous cycle finished");
  assert property (@(posedge clk) disable iff (rst) (eboxDone || portDone) |-> inCycle)
    else $error("done without a cycle in progress");

endmodule

bind cycleControl cycleControlProps i_props (
  .clk       (clk),
  .rst       (rst),
  .mbValid   (mbValid),
  .chanValid (chanValid),
  .eboxValid (eboxValid),
  .ccaValid  (ccaValid),
  .mbReady   (mbReady),
  .chanReady (chanReady),
  .eboxReady (eboxReady),
  .ccaReady  (ccaReady),
  .cacheIdle (cacheIdle),
  .eboxStart (eboxStart),
  .portStart (portStart),
  .eboxDone  (eboxDone),
  .portDone  (portDone)
);

`default_nettype wire

//--- verif/cacheControlTb.sv
// Directed testbench for cacheControl, built from files.f together with the bound assertions
`timescale 1ns/100ps
`default_nettype none

module cacheControlTb;

  import cshPkg::*;

  localparam int numWays = 4;
  localparam int numRequests = 17;
  localparam int maxCoreDelay = 15;
  localparam int diagDelay = 10;
  localparam int cycleLimit = 8 + 20 * numRequests + maxCoreDelay;

  // Pulse word order: eboxResp cacheWrEn coreWrReq fillWrEn chanWrCache chanRdCache ccaInval
  localparam logic [6:0] pResp = 7'h40;
  localparam logic [6:0] pCacheWr = 7'h20;
  localparam logic [6:0] pCoreWr = 7'h10;
  localparam logic [6:0] pFill = 7'h08;
  localparam logic [6:0] pChanWr = 7'h04;
  localparam logic [6:0] pChanRd = 7'h02;
  localparam logic [6:0] pInval = 7'h01;
  localparam logic [6:0] pNone = 7'h00;

  logic               clk;
  logic               rst;
  logic               mbValid;
  logic               mbReady;
  logic               chanValid;
  logic               chanReady;
  logic               chanToMem;
  logic               eboxValid;
  logic               eboxReady;
  logic               eboxRead;
  logic               ccaValid;
  logic               ccaReady;
  logic               ccaInvalEn;
  logic [numWays-1:0] validMatch;
  logic [numWays-1:0] wdVal;
  logic               coreDataValid;
  logic [2:0]         diagSel;
  logic               diagBit;
  logic               cacheIdle;
  logic               eboxResp;
  logic               cacheWrEn;
  logic               coreWrReq;
  logic               coreRdReq;
  logic               fillWrEn;
  logic               chanWrCache;
  logic               chanRdCache;
  logic               ccaInval;
  logic [31:0]        lfsr;
  int                 cycles = 0;

  cacheControl #(.numWays(numWays)) i_dut (
    .clk           (clk),
    .rst           (rst),
    .mbValid       (mbValid),
    .mbReady       (mbReady),
    .chanValid     (chanValid),
    .chanReady     (chanReady),
    .chanToMem     (chanToMem),
    .eboxValid     (eboxValid),
    .eboxReady     (eboxReady),
    .eboxRead      (eboxRead),
    .ccaValid      (ccaValid),
    .ccaReady      (ccaReady),
    .ccaInvalEn    (ccaInvalEn),
    .validMatch    (validMatch),
    .wdVal         (wdVal),
    .coreDataValid (coreDataValid),
    .diagSel       (diagSel),
    .diagBit       (diagBit),
    .cacheIdle     (cacheIdle),
    .eboxResp      (eboxResp),
    .cacheWrEn     (cacheWrEn),
    .coreWrReq     (coreWrReq),
    .coreRdReq     (coreRdReq),
    .fillWrEn      (fillWrEn),
    .chanWrCache   (chanWrCache),
    .chanRdCache   (chanRdCache),
    .ccaInval      (ccaInval)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= cycleLimit) begin
      $display("Timeout, the tests did not finish within %0d cycles", cycleLimit);
      $display("TB FAILED");
      $fatal(1, "timeout");
    end
  end

  // Taps 32 22 2 1
  function automatic logic lfsrBit();
    logic fb;
    fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic int randBits(input int n);
    int v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      v = (v << 1) | int'(lfsrBit());
    end
    return v;
  endfunction

  function automatic logic [numWays-1:0] randWays();
    logic [numWays-1:0] v;
    for (int i = 0; i < numWays; i++) begin
      v[i] = lfsrBit();
    end
    return v;
  endfunction

  function automatic logic [numReq-1:0] onehot(input int idx);
    logic [numReq-1:0] v;
    v = '0;
    v[idx] = 1'b1;
    return v;
  endfunction

  function automatic logic [numReq-1:0] readyVec();
    logic [numReq-1:0] v;
    v[reqMb] = mbReady;
    v[reqChan] = chanReady;
    v[reqEbox] = eboxReady;
    v[reqCca] = ccaReady;
    return v;
  endfunction

  task automatic stopOnError();
    $display("TB FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      stopOnError();
    end
  endtask

  task automatic checkType(input string name, input logic [numReq-1:0] got,
                           input logic [numReq-1:0] exp);
    if (got !== exp) begin
      $display("** Error: %s = 0x%0h, expected 0x%0h", name, got, exp);
      stopOnError();
    end
  endtask

  task automatic checkDiag(input logic [2:0] sel, input logic got, input logic exp);
    if (got !== exp) begin
      $display("** Error: diagBit at diagSel 0x%0h = 0x%0h, expected 0x%0h", sel, got, exp);
      stopOnError();
    end
  endtask

  task automatic checkPulses(input logic [6:0] exp);
    checkBit("eboxResp", eboxResp, exp[6]);
    checkBit("cacheWrEn", cacheWrEn, exp[5]);
    checkBit("coreWrReq", coreWrReq, exp[4]);
    checkBit("fillWrEn", fillWrEn, exp[3]);
    checkBit("chanWrCache", chanWrCache, exp[2]);
    checkBit("chanRdCache", chanRdCache, exp[1]);
    checkBit("ccaInval", ccaInval, exp[0]);
  endtask

  task automatic driveEdge();
    @(posedge clk);
    #10;
  endtask

  task automatic setValid(input int idx, input logic val);
    case (idx)
      reqMb: mbValid = val;
      reqChan: chanValid = val;
      reqEbox: eboxValid = val;
      default: ccaValid = val;
    endcase
  endtask

  // Returns at the drive point of the cycle after the accepting edge
  task automatic request(input int idx);
    setValid(idx, 1'b1);
    @(negedge clk);
    while (readyVec() == '0) begin
      @(negedge clk);
    end
    checkType("ready", readyVec(), onehot(idx));
    driveEdge();
    setValid(idx, 1'b0);
  endtask

  // Done in cycle 4 after acceptance, idle again in cycle 5
  task automatic expectPulses(input int idx, input logic [6:0] exp);
    for (int k = 1; k <= 5; k++) begin
      if (k > 1) begin
        driveEdge();
      end
      @(negedge clk);
      if (k == 1) begin
        checkType("cycType", i_dut.cycType, onehot(idx));
      end
      if (k <= 4) begin
        checkType("ready", readyVec(), '0);
      end
      checkPulses(k == 4 ? exp : pNone);
      checkBit("coreRdReq", coreRdReq, 1'b0);
      checkBit("cacheIdle", cacheIdle, k > 4);
    end
  endtask

  task automatic missWait(input int delay, input logic doDiag);
    diagFields_s diagExp;
    logic [diagWidth-1:0] diagRaw;
    diagExp = '{eboxCyc: 1'b1, mbCyc: 1'b0, chanCyc: 1'b0, ccaCyc: 1'b0,
                cacheIdle: 1'b0, coreRdReq: 1'b1, eboxBusy: 1'b1, portBusy: 1'b0};
    diagRaw = diagExp;
    for (int k = 1; k <= 4; k++) begin
      if (k > 1) begin
        driveEdge();
      end
      @(negedge clk);
      if (k == 1) begin
        checkType("cycType", i_dut.cycType, onehot(reqEbox));
      end
      checkBit("coreRdReq", coreRdReq, k == 4);
      checkBit("cacheIdle", cacheIdle, 1'b0);
      checkPulses(pNone);
    end
    // Core request held while the data is outstanding
    for (int j = 0; j < delay; j++) begin
      driveEdge();
      diagSel = 3'(j);
      @(negedge clk);
      checkBit("coreRdReq", coreRdReq, 1'b1);
      checkBit("cacheIdle", cacheIdle, 1'b0);
      checkPulses(pNone);
      if (doDiag && j < diagWidth) begin
        checkDiag(diagSel, diagBit, diagRaw[j]);
      end
    end
    driveEdge();
    coreDataValid = 1'b1;
    @(negedge clk);
    checkBit("coreRdReq", coreRdReq, 1'b1);
    checkPulses(pNone);
    driveEdge();
    coreDataValid = 1'b0;
    @(negedge clk);
    checkBit("coreRdReq", coreRdReq, 1'b0);
    checkBit("cacheIdle", cacheIdle, 1'b0);
    checkPulses(pResp);
    driveEdge();
    @(negedge clk);
    checkBit("cacheIdle", cacheIdle, 1'b1);
    checkPulses(pNone);
  endtask

  task automatic eboxCycle(input logic read, input logic [numWays-1:0] vm,
                           input logic [numWays-1:0] wd, input int delay,
                           input logic doDiag);
    logic found;
    found = |(vm & wd);
    driveEdge();
    eboxRead = read;
    validMatch = vm;
    wdVal = wd;
    request(reqEbox);
    if (!read) begin
      expectPulses(reqEbox, |vm ? pCacheWr : pCoreWr);
    end else if (found) begin
      expectPulses(reqEbox, pResp);
    end else begin
      missWait(delay, doDiag);
    end
  endtask

  task automatic portCycle(input int idx, input logic toMem, input logic invalEn,
                           input logic [numWays-1:0] vm);
    logic [6:0] exp;
    if (idx == reqMb)
      exp = pFill;
    else if (idx == reqChan)
      exp = !(|vm) ? pNone : (toMem ? pChanWr : pChanRd);
    else
      exp = (|vm && invalEn) ? pInval : pNone;
    driveEdge();
    chanToMem = toMem;
    ccaInvalEn = invalEn;
    validMatch = vm;
    request(idx);
    expectPulses(idx, exp);
  endtask

  task automatic priorityOrder();
    int order[4];
    logic [6:0] exp[4];
    order = '{reqMb, reqChan, reqEbox, reqCca};
    exp = '{pFill, pChanWr, pCacheWr, pNone};
    driveEdge();
    chanToMem = 1'b1;
    ccaInvalEn = 1'b0;
    eboxRead = 1'b0;
    validMatch = numWays'(1);
    mbValid = 1'b1;
    chanValid = 1'b1;
    eboxValid = 1'b1;
    ccaValid = 1'b1;
    @(negedge clk);
    for (int i = 0; i < numReq; i++) begin
      checkType("ready", readyVec(), onehot(order[i]));
      driveEdge();
      setValid(order[i], 1'b0);
      expectPulses(order[i], exp[i]);
    end
  endtask

  // Channel waits through an EBOX write miss and is taken at done+1
  task automatic backPressure();
    driveEdge();
    eboxRead = 1'b0;
    validMatch = '0;
    chanToMem = 1'b0;
    request(reqEbox);
    chanValid = 1'b1;
    expectPulses(reqEbox, pCoreWr);
    checkType("ready", readyVec(), onehot(reqChan));
    driveEdge();
    chanValid = 1'b0;
    expectPulses(reqChan, pNone);
  endtask

  initial begin
    logic [numWays-1:0] vm;
    logic [numWays-1:0] wd;
    int w;
    clk = 1'b0;
    rst = 1'b1;
    mbValid = 1'b0;
    chanValid = 1'b0;
    chanToMem = 1'b0;
    eboxValid = 1'b0;
    eboxRead = 1'b0;
    ccaValid = 1'b0;
    ccaInvalEn = 1'b0;
    validMatch = '0;
    wdVal = '0;
    coreDataValid = 1'b0;
    diagSel = 3'd0;
    lfsr = 32'h4a62_6b66;
    repeat (8) @(posedge clk);
    #10;
    rst = 1'b0;
    @(negedge clk);
    checkBit("cacheIdle", cacheIdle, 1'b1);
    checkType("ready", readyVec(), '0);
    checkBit("coreRdReq", coreRdReq, 1'b0);
    checkPulses(pNone);

    priorityOrder();

    // Read hit needs wdVal on a matching way
    vm = randWays();
    w = randBits($clog2(numWays));
    vm[w] = 1'b1;
    wd = randWays();
    wd[w] = 1'b1;
    eboxCycle(1'b1, vm, wd, 0, 1'b0);
    vm = randWays();
    wd = randWays() & ~vm;
    w = randBits(4);
    eboxCycle(1'b1, vm, wd, w, 1'b0);

    vm = randWays();
    w = randBits($clog2(numWays));
    vm[w] = 1'b1;
    eboxCycle(1'b0, vm, '0, 0, 1'b0);
    eboxCycle(1'b0, '0, '0, 0, 1'b0);
    eboxCycle(1'b1, randWays(), '0, diagDelay, 1'b1);

    portCycle(reqMb, 1'b0, 1'b0, randWays());
    portCycle(reqChan, 1'b1, 1'b0, vm);
    portCycle(reqChan, 1'b0, 1'b0, vm);
    portCycle(reqChan, 1'b1, 1'b0, '0);
    portCycle(reqCca, 1'b0, 1'b1, vm);
    portCycle(reqCca, 1'b0, 1'b0, vm);

    backPressure();

    $display("TB PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- files.f
src/cshPkg.sv
src/cycleControl.sv
src/eboxSequencer.sv
src/portSequencer.sv
src/cacheControl.sv
verif/cacheControl_props.sv
verif/cacheControlTb.sv

//--- run.sh
#!/bin/sh
# Build the cacheControl testbench with Verilator and run it, exit status is the verdict
verilator --binary --timing --assert -f files.f --top-module cacheControlTb -o simv \
  && ./obj_dir/simv \
  || exit 1
